// File: common/cu_consts.svh
`ifndef CU_CONSTS_SVH
`define CU_CONSTS_SVH

// Instruction word layout
`define INSTR_W 16
`define OPC_HI 15
`define OPC_LO 12
`define OPC_W (`OPC_HI - `OPC_LO + 1)
`define FUNCT_W 3
`define SHAMT_W 6

// Control field widths
`define SEL_W 2
`define KIND_W 3
`define DIR_W 2

// Step numbering, step 0 means no instruction in flight
`define STEP_W 4
`define STEP_IDLE 4'd0
`define STEP_SETUP 4'd1
`define STEP_EXEC 4'd2 // Branch compare, jump PC load, shift loop
`define STEP_WB 4'd3
`define STEP_BR_PC 4'd4
`define STEP_BR_END 4'd5

`endif

// File: common/cuPkg.sv
`include "cu_consts.svh"

package cuPkg;

	typedef enum logic [`OPC_W-1:0]
	{
		RTYPE = 4'd0,
		ADDI = 4'd1,
		ANDI = 4'd2,
		SLL = 4'd4,
		SRL = 4'd5,
		SRA = 4'd6,
		BREQ = 4'd13,
		BRNE = 4'd14,
		JUMP = 4'd15
	} opcodeT;

	// Encoded as the R-type funct field
	typedef enum logic [`FUNCT_W-1:0]
	{
		ADD = 3'b000,
		SUB = 3'b001,
		OR = 3'b011,
		AND = 3'b100,
		SLT = 3'b101,
		XOR = 3'b110
	} aluOpT;

	typedef enum logic [`KIND_W-1:0]
	{
		KIND_ALU,
		KIND_SLT,
		KIND_IMM,
		KIND_SHIFT,
		KIND_BRANCH,
		KIND_JUMP,
		KIND_NONE
	} opKindT;

	typedef enum logic [`SEL_W-1:0] {PC_SEQ = 2'b00, PC_JUMP = 2'b01, PC_BRANCH = 2'b10} pcSelT;

	typedef enum logic [`SEL_W-1:0] {SEL_REG = 2'b00, SEL_PC = 2'b01, SEL_RF = 2'b10, SEL_IMM = 2'b11} operandSelT;

	typedef enum logic [`DIR_W-1:0] {SH_LEFT, SH_LOGIC_RIGHT, SH_ARITH_RIGHT} shiftDirT;

endpackage

// File: hdl/instrFetch.sv
`timescale 1ns/1ps
`include "cu_consts.svh"

module instrFetch
(
	input logic CLK,
	input logic rstN,
	input logic fetchAck,
	input logic [`INSTR_W-1:0] instrIn,
	input logic instrDone,
	output logic fetchReq,
	output logic fetchPcEn,
	output logic [`INSTR_W-1:0] instrWord,
	output logic instrValid
);

	typedef enum logic [1:0] {IDLE, REQ, WAIT_DROP, HOLD} fetchStateT;

	fetchStateT state;
	fetchStateT nextState;
	logic capture;

	assign capture = (state == REQ) && fetchAck;

	always_comb
	begin
		nextState = state;
		case (state)
			IDLE:
				nextState = REQ;
			REQ:
				if (fetchAck)
					nextState = WAIT_DROP;
			WAIT_DROP:
				if (!fetchAck) // Four-phase return to zero
					nextState = HOLD;
			HOLD:
				if (instrDone)
					nextState = REQ;
			default:
				nextState = IDLE;
		endcase
	end

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			fetchPcEn <= 1'b0;
		end
		else
		begin
			state <= nextState;
			fetchPcEn <= capture; // PC advances once per fetched word
		end
	end

	always_ff @(posedge CLK)
	begin
		if (capture)
			instrWord <= instrIn;
	end

	assign fetchReq = (state == REQ);
	assign instrValid = (state == HOLD);

endmodule

// File: hdl/opDecoder.sv
`timescale 1ns/1ps
`include "cu_consts.svh"

module opDecoder
	import cuPkg::*;
(
	input logic [`INSTR_W-1:0] instrWord,
	output opKindT opKind,
	output aluOpT aluOp,
	output logic [`SHAMT_W-1:0] shiftAmt,
	output shiftDirT shiftDir,
	output logic branchOnZero
);

	opcodeT opcode;
	aluOpT funct;

	assign opcode = opcodeT'(instrWord[`OPC_HI:`OPC_LO]);
	assign funct = aluOpT'(instrWord[`FUNCT_W-1:0]);
	assign shiftAmt = instrWord[`SHAMT_W-1:0];

	always_comb
	begin
		opKind = KIND_NONE;
		aluOp = ADD;
		shiftDir = SH_LEFT;
		branchOnZero = 1'b0;
		case (opcode)
			RTYPE:
			begin
				case (funct)
					ADD, SUB, OR, AND, XOR:
					begin
						opKind = KIND_ALU;
						aluOp = funct;
					end
					SLT:
					begin
						opKind = KIND_SLT;
						aluOp = SLT;
					end
					default:
						opKind = KIND_NONE; // Old multiply and spare functs
				endcase
			end
			ADDI:
			begin
				opKind = KIND_IMM;
				aluOp = ADD;
			end
			ANDI:
			begin
				opKind = KIND_IMM;
				aluOp = AND;
			end
			SLL:
				opKind = KIND_SHIFT;
			SRL:
			begin
				opKind = KIND_SHIFT;
				shiftDir = SH_LOGIC_RIGHT;
			end
			SRA:
			begin
				opKind = KIND_SHIFT;
				shiftDir = SH_ARITH_RIGHT;
			end
			BREQ, BRNE:
			begin
				opKind = KIND_BRANCH;
				aluOp = SUB; // Compare by subtraction
				branchOnZero = (opcode == BREQ);
			end
			JUMP:
				opKind = KIND_JUMP;
			default:
				opKind = KIND_NONE; // Loads, stores and spare opcodes
		endcase
	end

endmodule

// File: sequencer/stepSequencer.sv
`timescale 1ns/1ps
`include "cu_consts.svh"

module stepSequencer
	import cuPkg::*;
(
	input logic CLK,
	input logic rstN,
	input logic instrValid,
	input opKindT opKind,
	input logic [`SHAMT_W-1:0] shiftAmt,
	input logic branchOnZero,
	input logic zFlag,
	input logic nFlag,
	output logic [`STEP_W-1:0] step,
	output logic shiftActive,
	output logic takeBranch,
	output logic sltNeg,
	output logic instrDone
);

	logic [`STEP_W-1:0] stepCnt;
	logic [`SHAMT_W-1:0] shiftCnt;
	logic lastStep;
	logic inShift;
	logic inBranch;
	logic inSlt;

	assign inShift = instrValid && (opKind == KIND_SHIFT);
	assign inBranch = instrValid && (opKind == KIND_BRANCH);
	assign inSlt = instrValid && (opKind == KIND_SLT);

	assign step = instrValid ? stepCnt : `STEP_IDLE;

	// Step counter parks on the shift step while bits remain
	assign shiftActive = inShift && (stepCnt == `STEP_EXEC) && (shiftCnt != '0);

	always_comb
	begin
		case (opKind)
			KIND_ALU, KIND_SLT, KIND_IMM, KIND_JUMP:
				lastStep = (stepCnt == `STEP_WB);
			KIND_BRANCH:
				lastStep = (stepCnt == `STEP_BR_END);
			KIND_SHIFT:
				lastStep = (stepCnt == `STEP_EXEC) && (shiftCnt == '0);
			default:
				lastStep = (stepCnt == `STEP_SETUP); // No-op just refetches
		endcase
	end

	assign instrDone = instrValid && lastStep;

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
			stepCnt <= `STEP_SETUP;
		else if (instrDone)
			stepCnt <= `STEP_SETUP;
		else if (instrValid && !shiftActive)
			stepCnt <= stepCnt + 1'b1;
	end

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
			shiftCnt <= '0;
		else if (inShift && (stepCnt == `STEP_SETUP))
			shiftCnt <= shiftAmt;
		else if (shiftActive)
			shiftCnt <= shiftCnt - 1'b1;
	end

	// Flags are valid at the end of the compare step
	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			takeBranch <= 1'b0;
			sltNeg <= 1'b0;
		end
		else
		begin
			if (inBranch && (stepCnt == `STEP_EXEC))
				takeBranch <= (zFlag == branchOnZero);
			if (inSlt && (stepCnt == `STEP_SETUP))
				sltNeg <= nFlag;
		end
	end

endmodule

// File: sequencer/controlWordGen.sv
`timescale 1ns/1ps
`include "cu_consts.svh"

module controlWordGen
	import cuPkg::*;
(
	input opKindT opKind,
	input aluOpT aluOp,
	input shiftDirT shiftDir,
	input logic [`STEP_W-1:0] step,
	input logic shiftActive,
	input logic takeBranch,
	input logic sltNeg,
	input logic fetchPcEn,
	output operandSelT aSel,
	output operandSelT bSel,
	output aluOpT aluOpOut,
	output logic lda,
	output logic rfEn,
	output logic sl,
	output logic sr,
	output logic srSel,
	output logic pcEn,
	output logic instTypeSel,
	output pcSelT pcMuxSel
);

	logic seqPcEn;

	always_comb
	begin
		aSel = SEL_REG;
		bSel = SEL_REG;
		aluOpOut = ADD;
		lda = 1'b0;
		rfEn = 1'b0;
		sl = 1'b0;
		sr = 1'b0;
		srSel = 1'b0;
		instTypeSel = 1'b0;
		pcMuxSel = PC_SEQ;
		seqPcEn = 1'b0;
		case (opKind)
			KIND_ALU, KIND_IMM:
			begin
				if (step != `STEP_IDLE)
				begin
					aSel = SEL_RF;
					if (opKind == KIND_IMM)
						bSel = SEL_IMM;
					else
						bSel = SEL_RF;
					aluOpOut = aluOp;
				end
				lda = (step == `STEP_SETUP) || (step == `STEP_EXEC);
				rfEn = (step == `STEP_WB);
			end
			KIND_SLT:
			begin
				case (step)
					`STEP_SETUP:
					begin
						aSel = SEL_RF;
						bSel = SEL_RF;
						aluOpOut = SUB;
					end
					`STEP_EXEC:
					begin
						lda = 1'b1;
						aluOpOut = aluOp;
					end
					`STEP_WB:
					begin
						if (sltNeg)
							bSel = SEL_IMM; // Constant one when a < b
						rfEn = 1'b1;
						aluOpOut = aluOp;
					end
				endcase
			end
			KIND_SHIFT:
			begin
				case (step)
					`STEP_SETUP:
					begin
						aSel = SEL_RF;
						lda = 1'b1;
					end
					`STEP_EXEC:
					begin
						aSel = SEL_RF;
						if (shiftActive)
						begin
							sl = (shiftDir == SH_LEFT);
							sr = (shiftDir != SH_LEFT);
							srSel = (shiftDir == SH_ARITH_RIGHT);
						end
						else
							rfEn = 1'b1;
					end
				endcase
			end
			KIND_BRANCH:
			begin
				case (step)
					`STEP_SETUP, `STEP_EXEC:
					begin
						instTypeSel = 1'b1;
						aSel = SEL_RF;
						bSel = SEL_RF;
						aluOpOut = aluOp;
					end
					`STEP_WB:
					begin
						aSel = SEL_PC; // Target is PC plus offset
						bSel = SEL_IMM;
						lda = 1'b1;
						if (takeBranch)
							pcMuxSel = PC_BRANCH;
					end
					`STEP_BR_PC:
					begin
						aSel = SEL_RF;
						bSel = SEL_IMM;
						if (takeBranch)
						begin
							pcMuxSel = PC_BRANCH;
							seqPcEn = 1'b1;
						end
					end
					`STEP_BR_END:
					begin
						aSel = SEL_RF;
						bSel = SEL_IMM;
					end
				endcase
			end
			KIND_JUMP:
			begin
				if (step != `STEP_IDLE)
				begin
					aSel = SEL_RF;
					bSel = SEL_IMM;
				end
				if ((step == `STEP_SETUP) || (step == `STEP_EXEC))
					pcMuxSel = PC_JUMP;
				seqPcEn = (step == `STEP_EXEC);
			end
			default:
				seqPcEn = 1'b0;
		endcase
		pcEn = fetchPcEn | seqPcEn;
	end

endmodule

// File: hdl/controlUnit.sv
`timescale 1ns/1ps
`include "cu_consts.svh"

module controlUnit
	import cuPkg::*;
(
	input logic CLK,
	input logic rstN,
	input logic fetchAck,
	input logic [`INSTR_W-1:0] instrIn,
	input logic zFlag,
	input logic nFlag,
	output logic fetchReq,
	output operandSelT aSel,
	output operandSelT bSel,
	output aluOpT aluOpOut,
	output logic lda,
	output logic rfEn,
	output logic sl,
	output logic sr,
	output logic srSel,
	output logic pcEn,
	output logic instTypeSel,
	output pcSelT pcMuxSel
);

	logic fetchPcEn;
	logic [`INSTR_W-1:0] instrWord;
	logic instrValid;
	logic instrDone;
	opKindT opKind;
	aluOpT aluOp;
	logic [`SHAMT_W-1:0] shiftAmt;
	shiftDirT shiftDir;
	logic branchOnZero;
	logic [`STEP_W-1:0] step;
	logic shiftActive;
	logic takeBranch;
	logic sltNeg;

	instrFetch fetch (.CLK(CLK), .rstN(rstN), .fetchAck(fetchAck), .instrIn(instrIn),
		.instrDone(instrDone), .fetchReq(fetchReq), .fetchPcEn(fetchPcEn),
		.instrWord(instrWord), .instrValid(instrValid));

	opDecoder decoder (.instrWord(instrWord), .opKind(opKind), .aluOp(aluOp),
		.shiftAmt(shiftAmt), .shiftDir(shiftDir), .branchOnZero(branchOnZero));

	stepSequencer sequencer (.CLK(CLK), .rstN(rstN), .instrValid(instrValid),
		.opKind(opKind), .shiftAmt(shiftAmt), .branchOnZero(branchOnZero),
		.zFlag(zFlag), .nFlag(nFlag), .step(step), .shiftActive(shiftActive),
		.takeBranch(takeBranch), .sltNeg(sltNeg), .instrDone(instrDone));

	controlWordGen ctrlWord (.opKind(opKind), .aluOp(aluOp), .shiftDir(shiftDir),
		.step(step), .shiftActive(shiftActive), .takeBranch(takeBranch),
		.sltNeg(sltNeg), .fetchPcEn(fetchPcEn), .aSel(aSel), .bSel(bSel),
		.aluOpOut(aluOpOut), .lda(lda), .rfEn(rfEn), .sl(sl), .sr(sr),
		.srSel(srSel), .pcEn(pcEn), .instTypeSel(instTypeSel), .pcMuxSel(pcMuxSel));

endmodule

// File: verification/tbControlUnit.sv
`timescale 1ns/1ps
`include "cu_consts.svh"

module tbControlUnit
	import cuPkg::*;
();

	localparam int instrCount = 200;
	localparam int reqTimeout = 120; // Longest shift plus setup and writeback
	localparam int ackTimeout = 8;
	localparam int endTimeout = 200;

	typedef struct packed
	{
		int rfCount;
		logic aluCheck;
		aluOpT aluOp;
		int shiftCycles;
		shiftDirT dir;
		pcSelT pcAction;
		logic sltCheck;
		operandSelT wbBSel;
	} expectT;

	logic CLK;
	logic rstN;
	logic fetchAck;
	logic [`INSTR_W-1:0] instrIn;
	logic zFlag;
	logic nFlag;
	logic fetchReq;
	operandSelT aSel;
	operandSelT bSel;
	aluOpT aluOpOut;
	logic lda;
	logic rfEn;
	logic sl;
	logic sr;
	logic srSel;
	logic pcEn;
	logic instTypeSel;
	pcSelT pcMuxSel;

	integer seed = 25249;
	int errors = 0;
	int checks = 0;
	int evaluated = 0;
	logic hang = 1'b0;
	string hangReason;

	// Issued words and their flags in issue order
	logic [`INSTR_W-1:0] wordQ[$];
	logic zQ[$];
	logic nQ[$];

	// Observations over one fetch window
	int rfCount;
	int slCycles;
	int srCycles;
	int srSelCycles;
	int lateShift;
	int fetchPulses;
	int seqPulses;
	aluOpT wbAluOp;
	operandSelT wbBSel;
	pcSelT obsPc;
	logic reqSeen = 1'b0;
	logic started = 1'b0;

	controlUnit uut (.CLK(CLK), .rstN(rstN), .fetchAck(fetchAck), .instrIn(instrIn),
		.zFlag(zFlag), .nFlag(nFlag), .fetchReq(fetchReq), .aSel(aSel), .bSel(bSel),
		.aluOpOut(aluOpOut), .lda(lda), .rfEn(rfEn), .sl(sl), .sr(sr), .srSel(srSel),
		.pcEn(pcEn), .instTypeSel(instTypeSel), .pcMuxSel(pcMuxSel));

	initial
	begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic checkAluOp(input aluOpT got, input aluOpT exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR at %0t: %s aluOp %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic checkPcSel(input pcSelT got, input pcSelT exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR at %0t: %s PC select %s, expected %s", $time, what, got.name(),
				exp.name());
		end
	endtask

	task automatic checkShift(input shiftDirT got, input shiftDirT exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR at %0t: %s shift %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic checkOperandSel(input operandSelT got, input operandSelT exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR at %0t: %s %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic checkCount(input int got, input int exp, input string what);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// Expected control activity for one instruction from the instruction set rules
	function automatic expectT refControl(input logic [`INSTR_W-1:0] word, input logic z,
		input logic n);
		expectT e;
		logic [`FUNCT_W-1:0] fn;
		e = '0;
		e.aluOp = ADD;
		e.dir = SH_LEFT;
		e.pcAction = PC_SEQ;
		e.wbBSel = SEL_REG;
		fn = word[`FUNCT_W-1:0];
		case (word[`OPC_HI:`OPC_LO])
			RTYPE:
			begin
				e.rfCount = 1;
				e.aluCheck = 1'b1;
				case (fn)
					3'b000: e.aluOp = ADD;
					3'b001: e.aluOp = SUB;
					3'b011: e.aluOp = OR;
					3'b100: e.aluOp = AND;
					3'b110: e.aluOp = XOR;
					3'b101:
					begin
						e.aluOp = SLT;
						e.sltCheck = 1'b1;
						e.wbBSel = n ? SEL_IMM : SEL_REG;
					end
					default:
					begin
						e.rfCount = 0; // Unsupported funct only refetches
						e.aluCheck = 1'b0;
					end
				endcase
			end
			ADDI:
			begin
				e.rfCount = 1;
				e.aluCheck = 1'b1;
				e.aluOp = ADD;
			end
			ANDI:
			begin
				e.rfCount = 1;
				e.aluCheck = 1'b1;
				e.aluOp = AND;
			end
			SLL, SRL, SRA:
			begin
				e.rfCount = 1;
				e.shiftCycles = word[`SHAMT_W-1:0];
				if (word[`OPC_HI:`OPC_LO] == SRL)
					e.dir = SH_LOGIC_RIGHT;
				else if (word[`OPC_HI:`OPC_LO] == SRA)
					e.dir = SH_ARITH_RIGHT;
			end
			BREQ:
				e.pcAction = z ? PC_BRANCH : PC_SEQ;
			BRNE:
				e.pcAction = z ? PC_SEQ : PC_BRANCH;
			JUMP:
				e.pcAction = PC_JUMP;
			default:
				e.rfCount = 0;
		endcase
		return e;
	endfunction

	function automatic logic [`INSTR_W-1:0] randomInstr();
		logic [`INSTR_W-1:0] word;
		int pick;
		word = $random(seed);
		pick = $unsigned($random(seed)) % 16;
		if (pick == 0)
		begin
			case ($unsigned($random(seed)) % 4)
				0: word[`OPC_HI:`OPC_LO] = 4'd3;
				1: word[`OPC_HI:`OPC_LO] = 4'd7;
				2: word[`OPC_HI:`OPC_LO] = 4'd9;
				default: word[`OPC_HI:`OPC_LO] = 4'd12;
			endcase
		end
		else if (pick == 1)
		begin
			word[`OPC_HI:`OPC_LO] = RTYPE;
			word[`FUNCT_W-1:0] = ($random(seed) & 1) ? 3'b111 : 3'b010; // Old multiply too
		end
		else
		begin
			case ($unsigned($random(seed)) % 9)
				0: word[`OPC_HI:`OPC_LO] = RTYPE;
				1: word[`OPC_HI:`OPC_LO] = ADDI;
				2: word[`OPC_HI:`OPC_LO] = ANDI;
				3: word[`OPC_HI:`OPC_LO] = SLL;
				4: word[`OPC_HI:`OPC_LO] = SRL;
				5: word[`OPC_HI:`OPC_LO] = SRA;
				6: word[`OPC_HI:`OPC_LO] = BREQ;
				7: word[`OPC_HI:`OPC_LO] = BRNE;
				default: word[`OPC_HI:`OPC_LO] = JUMP;
			endcase
			if (word[`OPC_HI:`OPC_LO] == RTYPE)
			begin
				case ($unsigned($random(seed)) % 6)
					0: word[`FUNCT_W-1:0] = ADD;
					1: word[`FUNCT_W-1:0] = SUB;
					2: word[`FUNCT_W-1:0] = OR;
					3: word[`FUNCT_W-1:0] = AND;
					4: word[`FUNCT_W-1:0] = SLT;
					default: word[`FUNCT_W-1:0] = XOR;
				endcase
			end
			if ((word[`OPC_HI:`OPC_LO] >= SLL) && (word[`OPC_HI:`OPC_LO] <= SRA))
				word[`SHAMT_W-1:0] = $unsigned($random(seed)) % 24; // Zero count shows up too
		end
		return word;
	endfunction

	// Answers one fetchReq with a random back-pressure delay on fetchAck
	task automatic serveFetch();
		int waitCycles;
		int delay;
		logic [`INSTR_W-1:0] word;
		waitCycles = 0;
		while (!fetchReq && (waitCycles < reqTimeout))
		begin
			@(posedge CLK);
			#2;
			waitCycles++;
		end
		if (!fetchReq)
		begin
			hang = 1'b1;
			hangReason = "the unit never requested the next instruction";
			return;
		end
		word = randomInstr();
		instrIn = word;
		zFlag = $random(seed);
		nFlag = $random(seed);
		wordQ.push_back(word);
		zQ.push_back(zFlag);
		nQ.push_back(nFlag);
		delay = $unsigned($random(seed)) % 6;
		repeat (delay)
		begin
			@(posedge CLK);
			#2;
		end
		fetchAck = 1'b1;
		waitCycles = 0;
		while (fetchReq && (waitCycles < ackTimeout))
		begin
			@(posedge CLK);
			#2;
			waitCycles++;
		end
		if (fetchReq)
		begin
			hang = 1'b1;
			hangReason = "the unit kept fetchReq high after fetchAck";
		end
		fetchAck = 1'b0;
	endtask

	task automatic clearWindow();
		rfCount = 0;
		slCycles = 0;
		srCycles = 0;
		srSelCycles = 0;
		lateShift = 0;
		fetchPulses = 0;
		seqPulses = 0;
		wbAluOp = ADD;
		wbBSel = SEL_REG;
		obsPc = PC_SEQ;
	endtask

	task automatic evaluateInstr();
		expectT e;
		string tag;
		shiftDirT obsDir;
		if (wordQ.size() == 0)
		begin
			errors++;
			$display("A fetch completed with no instruction issued at %0t", $time);
			return;
		end
		e = refControl(wordQ[0], zQ[0], nQ[0]);
		tag = $sformatf("instr %h", wordQ[0]);
		void'(wordQ.pop_front());
		void'(zQ.pop_front());
		void'(nQ.pop_front());
		checkCount(rfCount, e.rfCount, {tag, " rfEn pulses"});
		if (e.aluCheck)
			checkAluOp(wbAluOp, e.aluOp, tag);
		if (e.sltCheck)
			checkOperandSel(wbBSel, e.wbBSel, {tag, " bSel"});
		checkCount(slCycles, (e.dir == SH_LEFT) ? e.shiftCycles : 0, {tag, " sl cycles"});
		checkCount(srCycles, (e.dir != SH_LEFT) ? e.shiftCycles : 0, {tag, " sr cycles"});
		checkCount(srSelCycles, (e.dir == SH_ARITH_RIGHT) ? e.shiftCycles : 0,
			{tag, " srSel cycles"});
		checkCount(lateShift, 0, {tag, " shift cycles after rfEn"});
		if (e.shiftCycles > 0)
		begin
			obsDir = (slCycles > 0) ? SH_LEFT :
				((srSelCycles > 0) ? SH_ARITH_RIGHT : SH_LOGIC_RIGHT);
			checkShift(obsDir, e.dir, tag);
		end
		checkCount(fetchPulses, 1, {tag, " fetch pcEn pulses"});
		checkCount(seqPulses, (e.pcAction != PC_SEQ) ? 1 : 0, {tag, " jump or branch pcEn pulses"});
		checkPcSel(obsPc, e.pcAction, tag);
		evaluated++;
	endtask

	// Sampled mid-cycle away from the drive edge
	always @(negedge CLK)
	begin
		if (rstN)
		begin
			if (fetchReq && !reqSeen)
			begin
				if (started)
					evaluateInstr();
				started = 1'b1;
				clearWindow();
			end
			reqSeen = fetchReq;
			if (fetchReq)
			begin
				checkCount(int'(rfEn) + int'(lda) + int'(sl) + int'(sr) + int'(srSel) + int'(pcEn)
					+ int'(instTypeSel), 0, "active controls while waiting for fetchAck");
				checkPcSel(pcMuxSel, PC_SEQ, "waiting for fetchAck");
				checkAluOp(aluOpOut, ADD, "waiting for fetchAck");
				checkOperandSel(aSel, SEL_REG, "aSel while waiting for fetchAck");
				checkOperandSel(bSel, SEL_REG, "bSel while waiting for fetchAck");
			end
			if (rfEn)
			begin
				rfCount++;
				wbAluOp = aluOpOut;
				wbBSel = bSel;
			end
			if ((sl || sr) && (rfCount > 0))
				lateShift++;
			if (sl)
				slCycles++;
			if (sr)
				srCycles++;
			if (srSel)
				srSelCycles++;
			if (pcEn)
			begin
				if (pcMuxSel == PC_SEQ)
					fetchPulses++;
				else
				begin
					seqPulses++;
					obsPc = pcMuxSel;
				end
			end
		end
	end

	initial
	begin
		int waitCycles;
		rstN = 1'b0;
		fetchAck = 1'b0;
		instrIn = '0;
		zFlag = 1'b0;
		nFlag = 1'b0;
		clearWindow();
		repeat (4) @(posedge CLK);
		#2;
		rstN = 1'b1;
		for (int i = 0; (i < instrCount) && !hang; i++)
			serveFetch();
		waitCycles = 0;
		while (!hang && (evaluated < instrCount) && (waitCycles < endTimeout))
		begin
			@(posedge CLK);
			#2;
			waitCycles++;
		end
		if (!hang && (evaluated < instrCount))
		begin
			hang = 1'b1;
			hangReason = "the last instruction never completed";
		end
		if (hang)
			$display("Run stopped early: %s", hangReason);
		$display("Instructions checked: %0d, checks: %0d, errors: %0d", evaluated, checks, errors);
		if (!hang && (errors == 0))
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: compile.f
+incdir+common
common/cuPkg.sv
hdl/instrFetch.sv
hdl/opDecoder.sv
sequencer/stepSequencer.sv
sequencer/controlWordGen.sv
hdl/controlUnit.sv
verification/tbControlUnit.sv
